/* design/cpuPkg.sv */
/* Widths, encodings and the decoded-instruction format shared by the core
   Opcode and function values are fixed by the ISA; PC counts words */
`default_nettype none

package cpuPkg;

    localparam int dataWidth    = 32;  // Datapath, PC and memory word
    localparam int regAddrWidth = 5;   // 32 architectural registers

    // Primary opcode, instr[31:27]
    typedef enum logic [4:0] {
        opAlu  = 5'b00000,  // R-type, function in instr[6:2]
        opJ    = 5'b00001,
        opBne  = 5'b00010,
        opJal  = 5'b00011,
        opJr   = 5'b00100,
        opAddi = 5'b00101,
        opBlt  = 5'b00110,
        opSw   = 5'b00111,
        opLw   = 5'b01000,
        opSetx = 5'b10101,
        opBex  = 5'b10110
    } opcodeE;

    // R-type function, instr[6:2]; mul and div codes are not decoded
    typedef enum logic [4:0] {
        aluAdd = 5'b00000,
        aluSub = 5'b00001,
        aluAnd = 5'b00010,
        aluOr  = 5'b00011,
        aluSll = 5'b00100,
        aluSra = 5'b00101
    } aluOpE;

    // clsNop must stay zero so that an all-zero struct is a bubble
    typedef enum logic [4:0] {
        clsNop, clsAdd, clsAddi, clsSub, clsAnd, clsOr, clsSll, clsSra,
        clsLw, clsSw, clsBne, clsBlt, clsJ, clsJal, clsJr, clsBex, clsSetx
    } instrClassE;

    localparam logic [regAddrWidth-1:0] regStatus = 5'd30;  // Exception status, setx target
    localparam logic [regAddrWidth-1:0] regReturn = 5'd31;  // jal link

    // Status codes written on signed overflow
    localparam logic [dataWidth-1:0] excAdd  = 32'd1;
    localparam logic [dataWidth-1:0] excAddi = 32'd2;
    localparam logic [dataWidth-1:0] excSub  = 32'd3;

    typedef struct packed {
        instrClassE              cls;
        logic [dataWidth-1:0]    imm;        // instr[16:0], sign-extended
        logic [dataWidth-1:0]    target;     // instr[26:0], zero-extended
        logic [regAddrWidth-1:0] regA;       // Zero when unused
        logic [regAddrWidth-1:0] regB;       // Zero when unused
        logic [regAddrWidth-1:0] destReg;
        logic                    willWrite;
        logic [4:0]              shamt;
        aluOpE                   aluOp;      // aluAdd for all non R-type
        logic                    valid;
    } decodedT;

endpackage

`default_nettype wire

/* design/bypassIf.sv */
/* Results offered by the memory and writeback stages to the forwarding logic
   Clock and reset travel along so the consumer can check what it receives */
`timescale 1ns/100ps
`default_nettype none

interface bypassIf (
    input wire logic clock,
    input wire logic arstN
);

    logic                            memWe;    // Never set for a load in memory
    logic [cpuPkg::regAddrWidth-1:0] memReg;
    logic [cpuPkg::dataWidth-1:0]    memData;  // ALU result held in X/M
    logic                            wbWe;
    logic [cpuPkg::regAddrWidth-1:0] wbReg;
    logic [cpuPkg::dataWidth-1:0]    wbData;   // Loaded or computed value

    modport producer (output memWe, memReg, memData, wbWe, wbReg, wbData);
    modport consumer (input clock, arstN, memWe, memReg, memData, wbWe, wbReg, wbData);

endinterface

`default_nettype wire

/* design/instrDecode.sv */
/* Combinational decoder for the decode stage
   Unknown opcodes and R-type functions, mul and div included, decode as a bubble */
`timescale 1ns/100ps
`default_nettype none

module instrDecode (
    input  wire logic [cpuPkg::dataWidth-1:0] instr,
    output cpuPkg::decodedT                   dec
);

    cpuPkg::opcodeE                  op;
    cpuPkg::aluOpE                   func;
    cpuPkg::instrClassE              cls;
    logic [cpuPkg::regAddrWidth-1:0] rd, rs, rt;
    logic                            isRType;

    assign op   = cpuPkg::opcodeE'(instr[31:27]);
    assign func = cpuPkg::aluOpE'(instr[6:2]);
    assign rd   = instr[26:22];
    assign rs   = instr[21:17];
    assign rt   = instr[16:12];

    always_comb begin
        case (op)
            cpuPkg::opAlu: begin
                case (func)
                    cpuPkg::aluAdd: cls = cpuPkg::clsAdd;
                    cpuPkg::aluSub: cls = cpuPkg::clsSub;
                    cpuPkg::aluAnd: cls = cpuPkg::clsAnd;
                    cpuPkg::aluOr:  cls = cpuPkg::clsOr;
                    cpuPkg::aluSll: cls = cpuPkg::clsSll;
                    cpuPkg::aluSra: cls = cpuPkg::clsSra;
                    default:        cls = cpuPkg::clsNop;
                endcase
            end
            cpuPkg::opAddi: cls = cpuPkg::clsAddi;
            cpuPkg::opLw:   cls = cpuPkg::clsLw;
            cpuPkg::opSw:   cls = cpuPkg::clsSw;
            cpuPkg::opBne:  cls = cpuPkg::clsBne;
            cpuPkg::opBlt:  cls = cpuPkg::clsBlt;
            cpuPkg::opJ:    cls = cpuPkg::clsJ;
            cpuPkg::opJal:  cls = cpuPkg::clsJal;
            cpuPkg::opJr:   cls = cpuPkg::clsJr;
            cpuPkg::opBex:  cls = cpuPkg::clsBex;
            cpuPkg::opSetx: cls = cpuPkg::clsSetx;
            default:        cls = cpuPkg::clsNop;
        endcase
    end

    assign isRType = cls inside {cpuPkg::clsAdd, cpuPkg::clsSub, cpuPkg::clsAnd,
                                 cpuPkg::clsOr, cpuPkg::clsSll, cpuPkg::clsSra};

    always_comb begin
        dec        = '0;
        dec.cls    = cls;
        dec.valid  = (cls != cpuPkg::clsNop);
        dec.imm    = {{15{instr[16]}}, instr[16:0]};
        dec.target = {5'b0, instr[26:0]};
        dec.shamt  = instr[11:7];
        dec.aluOp  = isRType ? func : cpuPkg::aluAdd;  // Address and addi use add
        // Port A: compared or jumped-to register first, else rs
        case (cls)
            cpuPkg::clsBne, cpuPkg::clsBlt, cpuPkg::clsJr: dec.regA = rd;
            cpuPkg::clsBex:                                dec.regA = cpuPkg::regStatus;
            cpuPkg::clsJ, cpuPkg::clsJal, cpuPkg::clsSetx,
            cpuPkg::clsNop:                                dec.regA = '0;
            default:                                       dec.regA = rs;
        endcase
        // Port B: rt, branch rs, or the store data register
        if (isRType) begin
            dec.regB = rt;
        end else if (cls inside {cpuPkg::clsBne, cpuPkg::clsBlt}) begin
            dec.regB = rs;
        end else if (cls == cpuPkg::clsSw) begin
            dec.regB = rd;
        end
        // Destination before any overflow rewrite in execute
        if (isRType || cls inside {cpuPkg::clsAddi, cpuPkg::clsLw}) begin
            dec.destReg   = rd;
            dec.willWrite = 1'b1;
        end else if (cls == cpuPkg::clsJal) begin
            dec.destReg   = cpuPkg::regReturn;
            dec.willWrite = 1'b1;
        end else if (cls == cpuPkg::clsSetx) begin
            dec.destReg   = cpuPkg::regStatus;
            dec.willWrite = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/alu.sv */
/* Integer ALU: signed add and sub with overflow, and, or, sll, sra
   Compare flags always come from A minus B, whatever aluOp selects */
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire logic [cpuPkg::dataWidth-1:0] operandA,
    input  wire logic [cpuPkg::dataWidth-1:0] operandB,
    input  wire cpuPkg::aluOpE                aluOp,
    input  wire logic [4:0]                   shamt,
    output logic      [cpuPkg::dataWidth-1:0] result,
    output logic                              overflow,
    output logic                              notEqual,
    output logic                              lessThan
);

    localparam int msb = cpuPkg::dataWidth - 1;

    logic [msb:0] sum;
    logic [msb:0] diff;
    logic         addOvf;
    logic         subOvf;

    assign sum  = operandA + operandB;
    assign diff = operandA - operandB;

    // Same-sign inputs with a flipped result sign
    assign addOvf = (operandA[msb] == operandB[msb]) && (sum[msb] != operandA[msb]);
    assign subOvf = (operandA[msb] != operandB[msb]) && (diff[msb] != operandA[msb]);

    assign notEqual = |diff;
    assign lessThan = diff[msb] ^ subOvf;  // Signed A < B, corrected for wrap

    always_comb begin
        overflow = 1'b0;
        case (aluOp)
            cpuPkg::aluAdd: begin
                result   = sum;
                overflow = addOvf;
            end
            cpuPkg::aluSub: begin
                result   = diff;
                overflow = subOvf;
            end
            cpuPkg::aluAnd: result = operandA & operandB;
            cpuPkg::aluOr:  result = operandA | operandB;
            cpuPkg::aluSll: result = operandA << shamt;
            cpuPkg::aluSra: result = $signed(operandA) >>> shamt;
            default:        result = sum;
        endcase
    end

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
/* Execute operand forwarding, store-data bypass in memory and load-use stall
   Memory beats writeback; a load in memory is never offered for forwarding */
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
    input  wire logic [cpuPkg::regAddrWidth-1:0] decReadA,
    input  wire logic [cpuPkg::regAddrWidth-1:0] decReadB,
    input  wire logic                            decUsesB,
    input  wire cpuPkg::decodedT                 exDec,
    input  wire logic [cpuPkg::dataWidth-1:0]    exValA,
    input  wire logic [cpuPkg::dataWidth-1:0]    exValB,
    input  wire logic [cpuPkg::regAddrWidth-1:0] memStoreReg,
    input  wire logic [cpuPkg::dataWidth-1:0]    memStoreVal,
    bypassIf.consumer                            byp,
    output logic      [cpuPkg::dataWidth-1:0]    fwdA,
    output logic      [cpuPkg::dataWidth-1:0]    fwdB,
    output logic      [cpuPkg::dataWidth-1:0]    storeData,
    output logic                                 loadUseStall
);

    logic memHitA, wbHitA;
    logic memHitB, wbHitB;
    logic wbHitStore;
    logic loadInEx;

    // Register 0 reads as zero and is never forwarded
    assign memHitA = byp.memWe && (byp.memReg == exDec.regA) && (exDec.regA != '0);
    assign wbHitA  = byp.wbWe  && (byp.wbReg  == exDec.regA) && (exDec.regA != '0);
    assign memHitB = byp.memWe && (byp.memReg == exDec.regB) && (exDec.regB != '0);
    assign wbHitB  = byp.wbWe  && (byp.wbReg  == exDec.regB) && (exDec.regB != '0);

    assign fwdA = memHitA ? byp.memData : (wbHitA ? byp.wbData : exValA);
    assign fwdB = memHitB ? byp.memData : (wbHitB ? byp.wbData : exValB);

    // W to M path, covers a store right behind the load that feeds it
    assign wbHitStore = byp.wbWe && (byp.wbReg == memStoreReg) && (memStoreReg != '0);
    assign storeData  = wbHitStore ? byp.wbData : memStoreVal;

    // Load in execute feeding decode costs one bubble
    assign loadInEx     = exDec.valid && (exDec.cls == cpuPkg::clsLw) && (exDec.destReg != '0);
    assign loadUseStall = loadInEx && ((decReadA == exDec.destReg) ||
                                       (decUsesB && (decReadB == exDec.destReg)));

    // Exactly one bubble per load-use pair
    singleBubble: assert property (@(posedge byp.clock) disable iff (!byp.arstN)
        loadUseStall |=> !loadUseStall)
        else $error("hazardUnit: load-use stall held for more than one cycle");

endmodule

`default_nettype wire

/* design/executeStage.sv */
/* Execute stage: operand select, ALU, branch and jump resolution
   Branch targets are PC+1+imm in words; overflow and setx rewrite the result to r30 */
`timescale 1ns/100ps
`default_nettype none

module executeStage (
    input  wire cpuPkg::decodedT                 dec,
    input  wire logic [cpuPkg::dataWidth-1:0]    pc,
    input  wire logic [cpuPkg::dataWidth-1:0]    opA,
    input  wire logic [cpuPkg::dataWidth-1:0]    opB,
    output logic      [cpuPkg::dataWidth-1:0]    result,
    output logic      [cpuPkg::regAddrWidth-1:0] destReg,
    output logic                                 destWe,
    output logic                                 isLoad,
    output logic                                 isStore,
    output logic      [cpuPkg::dataWidth-1:0]    storeVal,
    output logic                                 redirect,
    output logic      [cpuPkg::dataWidth-1:0]    redirectPc
);

    logic [cpuPkg::dataWidth-1:0] aluB, aluResult, pcNext, excCode;
    logic useImm, overflow, notEqual, lessThan;
    logic takeBranch, takeTarget, exception;

    assign useImm = dec.cls inside {cpuPkg::clsAddi, cpuPkg::clsLw, cpuPkg::clsSw};
    assign aluB   = useImm ? dec.imm : opB;

    alu alu_i (
        .operandA (opA),
        .operandB (aluB),
        .aluOp    (dec.aluOp),
        .shamt    (dec.shamt),
        .result   (aluResult),
        .overflow (overflow),
        .notEqual (notEqual),
        .lessThan (lessThan)
    );

    assign pcNext = pc + cpuPkg::dataWidth'(1);

    // bne and blt compare rd (A) against rs (B); bex compares r30 against r0
    assign takeBranch = ((dec.cls == cpuPkg::clsBne) && notEqual) ||
                        ((dec.cls == cpuPkg::clsBlt) && lessThan);
    assign takeTarget = (dec.cls inside {cpuPkg::clsJ, cpuPkg::clsJal}) ||
                        ((dec.cls == cpuPkg::clsBex) && notEqual);
    assign redirect   = takeBranch || takeTarget || (dec.cls == cpuPkg::clsJr);

    always_comb begin
        if (takeBranch) begin
            redirectPc = pcNext + dec.imm;  // Relative, word units
        end else if (dec.cls == cpuPkg::clsJr) begin
            redirectPc = opA;
        end else begin
            redirectPc = dec.target;
        end
    end

    // Only add, addi and sub raise an exception
    assign exception = overflow &&
                       (dec.cls inside {cpuPkg::clsAdd, cpuPkg::clsAddi, cpuPkg::clsSub});

    always_comb begin
        case (dec.cls)
            cpuPkg::clsAdd:  excCode = cpuPkg::excAdd;
            cpuPkg::clsAddi: excCode = cpuPkg::excAddi;
            default:         excCode = cpuPkg::excSub;
        endcase
    end

    always_comb begin
        result  = aluResult;
        destReg = dec.destReg;  // r31 for jal, r30 for setx already
        if (exception) begin
            result  = excCode;
            destReg = cpuPkg::regStatus;
        end else if (dec.cls == cpuPkg::clsSetx) begin
            result = dec.target;
        end else if (dec.cls == cpuPkg::clsJal) begin
            result = pcNext;  // Link value
        end
    end

    assign destWe   = dec.valid && dec.willWrite && (destReg != '0);
    assign isLoad   = (dec.cls == cpuPkg::clsLw);
    assign isStore  = (dec.cls == cpuPkg::clsSw);
    assign storeVal = opB;  // rd of sw, bypassed again in memory

endmodule

`default_nettype wire

/* design/processor.sv */
/* Five-stage in-order core; register file and both memories are external, read combinationally
   The register file must return the value written in the same cycle */
`timescale 1ns/100ps
`default_nettype none

module processor #(
    parameter logic [cpuPkg::dataWidth-1:0] resetPc = '0  // Word address of first fetch
) (
    input  wire logic                               clock,
    input  wire logic                               arstN,
    output logic      [cpuPkg::dataWidth-1:0]       imemAddr,
    input  wire logic [cpuPkg::dataWidth-1:0]       imemData,
    output logic      [cpuPkg::dataWidth-1:0]       dmemAddr,
    output logic      [cpuPkg::dataWidth-1:0]       dmemWrData,
    output logic                                    dmemWe,
    input  wire logic [cpuPkg::dataWidth-1:0]       dmemRdData,
    output logic                                    rfWe,
    output logic      [cpuPkg::regAddrWidth-1:0]    rfWriteReg,
    output logic      [cpuPkg::regAddrWidth-1:0]    rfReadRegA,
    output logic      [cpuPkg::regAddrWidth-1:0]    rfReadRegB,
    output logic      [cpuPkg::dataWidth-1:0]       rfWriteData,
    input  wire logic [cpuPkg::dataWidth-1:0]       rfReadDataA,
    input  wire logic [cpuPkg::dataWidth-1:0]       rfReadDataB
);

    localparam int dw = cpuPkg::dataWidth;
    localparam int rw = cpuPkg::regAddrWidth;

    logic [dw-1:0] pcQ, fdInstr, fdPc, dxPc, dxA, dxB;
    logic [dw-1:0] fwdA, fwdB, storeData, redirectPc;
    logic [dw-1:0] exResult, exStoreVal, xmResult, xmStoreVal, memValue, mwData;
    logic [rw-1:0] exDest, xmDest, xmStoreReg, mwReg;
    logic          fdValid, stall, redirect, decUsesB;
    logic          exWe, exLoad, exStore, xmWe, xmLoad, xmStore, mwWe;
    cpuPkg::decodedT rawDec, decDec, dxDec;

    bypassIf byp (.clock(clock), .arstN(arstN));

    // Fetch
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pcQ <= resetPc;
        end else if (redirect) begin
            pcQ <= redirectPc;  // Taken branch or jump from execute
        end else if (!stall) begin
            pcQ <= pcQ + dw'(1);
        end
    end
    assign imemAddr = pcQ;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            fdValid <= 1'b0;
        end else if (redirect) begin
            fdValid <= 1'b0;   // Younger fetch squashed
        end else if (!stall) begin
            fdValid <= 1'b1;
        end
    end
    always_ff @(posedge clock) begin
        if (!stall) begin
            fdInstr <= imemData;
            fdPc    <= pcQ;
        end
    end

    // Decode
    instrDecode decode_i (.instr(fdInstr), .dec(rawDec));
    assign decDec     = fdValid ? rawDec : '0;     // All-zero struct is clsNop
    assign rfReadRegA = decDec.regA;
    assign rfReadRegB = decDec.regB;
    assign decUsesB   = (decDec.cls != cpuPkg::clsSw);  // sw data is fixed up in memory

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            dxDec <= '0;
        end else if (redirect || stall) begin
            dxDec <= '0;       // Bubble into execute
        end else begin
            dxDec <= decDec;
        end
    end
    always_ff @(posedge clock) begin
        dxPc <= fdPc;
        dxA  <= rfReadDataA;
        dxB  <= rfReadDataB;
    end

    // Execute
    hazardUnit hazard_i (
        .decReadA     (decDec.regA),
        .decReadB     (decDec.regB),
        .decUsesB     (decUsesB),
        .exDec        (dxDec),
        .exValA       (dxA),
        .exValB       (dxB),
        .memStoreReg  (xmStoreReg),
        .memStoreVal  (xmStoreVal),
        .byp          (byp),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .storeData    (storeData),
        .loadUseStall (stall)
    );

    executeStage execute_i (
        .dec        (dxDec),
        .pc         (dxPc),
        .opA        (fwdA),
        .opB        (fwdB),
        .result     (exResult),
        .destReg    (exDest),
        .destWe     (exWe),
        .isLoad     (exLoad),
        .isStore    (exStore),
        .storeVal   (exStoreVal),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            xmWe    <= 1'b0;
            xmLoad  <= 1'b0;
            xmStore <= 1'b0;
        end else begin
            xmWe    <= exWe;
            xmLoad  <= exLoad;
            xmStore <= exStore;
        end
    end
    always_ff @(posedge clock) begin
        xmResult   <= exResult;    // Also the memory address
        xmDest     <= exDest;
        xmStoreVal <= exStoreVal;
        xmStoreReg <= dxDec.regB;
    end

    // Memory
    assign dmemAddr   = xmResult;
    assign dmemWrData = storeData;
    assign dmemWe     = xmStore;
    assign memValue   = xmLoad ? dmemRdData : xmResult;

    assign byp.memWe   = xmWe && !xmLoad;  // Load data not ready yet
    assign byp.memReg  = xmDest;
    assign byp.memData = xmResult;

    // Writeback
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            mwWe <= 1'b0;
        end else begin
            mwWe <= xmWe;
        end
    end
    always_ff @(posedge clock) begin
        mwData <= memValue;
        mwReg  <= xmDest;
    end

    assign rfWe        = mwWe;
    assign rfWriteReg  = mwReg;
    assign rfWriteData = mwData;

    assign byp.wbWe   = mwWe;
    assign byp.wbReg  = mwReg;
    assign byp.wbData = mwData;

    // A load in memory never has a consumer in execute
    loadNotForwarded: assert property (@(posedge clock) disable iff (!arstN)
        (xmWe && xmLoad) |-> !((dxDec.regA == xmDest) ||
                               ((dxDec.cls != cpuPkg::clsSw) && (dxDec.regB == xmDest))))
        else $error("processor: load result needed in execute while still in memory");

endmodule

`default_nettype wire

/* verif/isaModel.svh */
/* Test program image and a one-instruction-at-a-time model of its register and memory writes
   Included inside the testbench module; the model stops at the first jump to itself */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH
`default_nettype none

function automatic logic [31:0] rIns(cpuPkg::aluOpE fn, logic [4:0] rd, logic [4:0] rs,
                                     logic [4:0] rt, logic [4:0] sh);
    return {cpuPkg::opAlu, rd, rs, rt, sh, fn, 2'b00};
endfunction

function automatic logic [31:0] iIns(cpuPkg::opcodeE op, logic [4:0] rd, logic [4:0] rs,
                                     logic [16:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic logic [31:0] jIns(cpuPkg::opcodeE op, logic [26:0] target);
    return {op, target};
endfunction

// Every byte lane derived from the full 8-bit word address
function automatic logic [31:0] fillWord(logic [7:0] addr);
    return {addr, ~addr, addr ^ 8'h5a, addr + 8'h3c};
endfunction

task automatic loadProgram();
    foreach (imem[i]) imem[i] = '0;                        // add r0,r0,r0 padding
    imem[0]  = iIns(cpuPkg::opAddi, 1, 0, 5);
    imem[1]  = iIns(cpuPkg::opAddi, 2, 1, 7);              // r1 from memory stage
    imem[2]  = rIns(cpuPkg::aluAdd, 3, 1, 2, 0);           // A from writeback, B from memory
    imem[3]  = rIns(cpuPkg::aluSub, 4, 3, 1, 0);
    imem[4]  = rIns(cpuPkg::aluOr,  5, 4, 3, 0);
    imem[5]  = rIns(cpuPkg::aluAnd, 6, 5, 4, 0);
    imem[6]  = rIns(cpuPkg::aluSll, 7, 6, 0, 4);
    imem[7]  = iIns(cpuPkg::opAddi, 8, 0, -64);
    imem[8]  = rIns(cpuPkg::aluSra, 9, 8, 0, 3);
    imem[9]  = iIns(cpuPkg::opSw,   9, 1, 10);             // Data from the instruction before
    imem[10] = iIns(cpuPkg::opLw,   10, 0, 15);
    imem[11] = rIns(cpuPkg::aluAdd, 11, 10, 7, 0);         // Load-use bubble
    imem[12] = iIns(cpuPkg::opLw,   12, 1, 3);
    imem[13] = iIns(cpuPkg::opSw,   12, 0, 20);            // Load straight into store data
    imem[14] = rIns(cpuPkg::aluAdd, 0, 1, 2, 0);           // Targets r0, no write
    imem[15] = iIns(cpuPkg::opBne,  1, 1, 5);              // Not taken
    imem[16] = iIns(cpuPkg::opBne,  1, 2, 2);              // Taken to 19
    imem[17] = iIns(cpuPkg::opAddi, 13, 0, 99);
    imem[18] = iIns(cpuPkg::opAddi, 13, 0, 98);
    imem[19] = iIns(cpuPkg::opBlt,  2, 1, 3);              // 12 < 5 fails
    imem[20] = iIns(cpuPkg::opBlt,  8, 1, 1);              // -64 < 5, taken to 22
    imem[21] = iIns(cpuPkg::opAddi, 14, 0, 77);
    imem[22] = jIns(cpuPkg::opJal,  26);
    imem[23] = jIns(cpuPkg::opJ,    29);
    imem[24] = iIns(cpuPkg::opAddi, 15, 0, 55);
    imem[25] = iIns(cpuPkg::opAddi, 15, 0, 56);
    imem[26] = iIns(cpuPkg::opAddi, 16, 31, 100);
    imem[27] = iIns(cpuPkg::opJr,   31, 0, 0);
    imem[28] = iIns(cpuPkg::opAddi, 17, 0, 1);
    imem[29] = jIns(cpuPkg::opBex,  60);                   // r30 still zero
    imem[30] = iIns(cpuPkg::opAddi, 18, 0, 17'h0ffff);
    imem[31] = rIns(cpuPkg::aluSll, 19, 18, 0, 15);        // 0x7fff8000
    imem[32] = rIns(cpuPkg::aluAdd, 20, 19, 19, 0);        // Overflow, code 1
    imem[33] = iIns(cpuPkg::opAddi, 21, 19, 17'h08000);    // Overflow, code 2
    imem[34] = iIns(cpuPkg::opAddi, 23, 0, -1);
    imem[35] = rIns(cpuPkg::aluSll, 24, 23, 0, 31);        // Most negative value
    imem[36] = rIns(cpuPkg::aluSub, 22, 24, 1, 0);         // Overflow, code 3
    imem[37] = jIns(cpuPkg::opBex,  41);
    imem[38] = iIns(cpuPkg::opAddi, 25, 0, 11);
    imem[39] = iIns(cpuPkg::opAddi, 25, 0, 12);
    imem[40] = iIns(cpuPkg::opAddi, 25, 0, 13);
    imem[41] = jIns(cpuPkg::opSetx, 27'h1234);
    imem[42] = jIns(cpuPkg::opBex,  45);                   // Status straight from setx
    imem[43] = iIns(cpuPkg::opAddi, 27, 0, 3);
    imem[44] = iIns(cpuPkg::opAddi, 27, 0, 4);
    imem[45] = rIns(cpuPkg::aluAdd, 26, 30, 16, 0);
    imem[46] = iIns(cpuPkg::opSw,   26, 1, 0);
    imem[47] = jIns(cpuPkg::opJ,    47);                   // Final loop
endtask

task automatic putReg(logic [4:0] idx, logic [31:0] val);
    if (idx != '0) begin
        refRegs[idx] = val;
        expRegIdx.push_back(idx);
        expRegVal.push_back(val);
    end
endtask

// Out of signed 32-bit range sends the code to the status register instead
task automatic putSum(logic [4:0] rd, longint wide, logic [31:0] code);
    if (wide > 64'sh7fff_ffff || wide < -64'sh8000_0000) begin
        putReg(30, code);
    end else begin
        putReg(rd, wide[31:0]);
    end
endtask

task automatic runModel();
    logic [31:0] pc, ins, a, b, imm, tgt, npc, addr;
    logic [4:0]  op, rd, rs, rt, sh, fn;
    logic        done;
    pc       = '0;
    done     = 1'b0;
    refCount = 0;
    foreach (refRegs[i]) refRegs[i] = '0;
    foreach (refMem[i]) refMem[i] = fillWord(i[7:0]);
    while (!done && refCount < 400) begin
        ins = imem[pc[5:0]];
        {op, rd, rs, rt, sh, fn} = ins[31:2];
        imm  = {{15{ins[16]}}, ins[16:0]};
        tgt  = {5'b0, ins[26:0]};
        a    = refRegs[rs];
        b    = refRegs[rt];
        addr = a + imm;
        npc  = pc + 1;
        refCount++;
        case (op)
            cpuPkg::opAlu: begin
                case (fn)
                    cpuPkg::aluAdd: putSum(rd, longint'($signed(a)) + longint'($signed(b)), 1);
                    cpuPkg::aluSub: putSum(rd, longint'($signed(a)) - longint'($signed(b)), 3);
                    cpuPkg::aluAnd: putReg(rd, a & b);
                    cpuPkg::aluOr:  putReg(rd, a | b);
                    cpuPkg::aluSll: putReg(rd, a << sh);
                    cpuPkg::aluSra: putReg(rd, $signed(a) >>> sh);
                    default: ;
                endcase
            end
            cpuPkg::opAddi: putSum(rd, longint'($signed(a)) + longint'($signed(imm)), 2);
            cpuPkg::opLw:   putReg(rd, refMem[addr[7:0]]);
            cpuPkg::opSw: begin
                refMem[addr[7:0]] = refRegs[rd];
                expMemAddr.push_back(addr);
                expMemVal.push_back(refRegs[rd]);
            end
            cpuPkg::opBne:  if (refRegs[rd] != a) npc = pc + 1 + imm;
            cpuPkg::opBlt:  if ($signed(refRegs[rd]) < $signed(a)) npc = pc + 1 + imm;
            cpuPkg::opJ:    npc = tgt;
            cpuPkg::opJal: begin
                putReg(31, pc + 1);
                npc = tgt;
            end
            cpuPkg::opJr:   npc = refRegs[rd];
            cpuPkg::opBex:  if (refRegs[30] != '0) npc = tgt;
            cpuPkg::opSetx: putReg(30, tgt);
            default: ;
        endcase
        if (npc == pc) begin
            loopPc = pc;                                   // Jump to itself ends the program
            done   = 1'b1;
        end
        pc = npc;
    end
endtask

`default_nettype wire
`endif

/* verif/tbProcessor.sv */
/* Testbench for the five-stage core with combinational memory and register file models
   Register and store writes are checked in order against the ISA model queues */
`timescale 1ns/100ps
`default_nettype none

module tbProcessor;

    localparam int dw = cpuPkg::dataWidth;
    localparam int rw = cpuPkg::regAddrWidth;

    logic          clock, arstN;
    logic [dw-1:0] imemAddr, imemData, dmemAddr, dmemWrData, dmemRdData;
    logic [dw-1:0] rfWriteData, rfReadDataA, rfReadDataB;
    logic [rw-1:0] rfWriteReg, rfReadRegA, rfReadRegB;
    logic          dmemWe, rfWe;

    logic [dw-1:0] imem [64];
    logic [dw-1:0] dmem [256];
    logic [dw-1:0] rf   [32];

    // ISA model state and expected write streams
    logic [dw-1:0] refRegs [32];
    logic [dw-1:0] refMem  [256];
    logic [rw-1:0] expRegIdx [$];
    logic [dw-1:0] expRegVal [$];
    logic [dw-1:0] expMemAddr [$];
    logic [dw-1:0] expMemVal [$];
    int            refCount;
    logic [dw-1:0] loopPc;
    int            loopFetches;

    processor #(.resetPc('0)) processor_i (
        .clock       (clock),
        .arstN       (arstN),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .dmemAddr    (dmemAddr),
        .dmemWrData  (dmemWrData),
        .dmemWe      (dmemWe),
        .dmemRdData  (dmemRdData),
        .rfWe        (rfWe),
        .rfWriteReg  (rfWriteReg),
        .rfReadRegA  (rfReadRegA),
        .rfReadRegB  (rfReadRegB),
        .rfWriteData (rfWriteData),
        .rfReadDataA (rfReadDataA),
        .rfReadDataB (rfReadDataB)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;                         // 4 ns period
    end

    // Combinational reads; r0 is hardwired, same-cycle writes pass through
    assign imemData    = imem[imemAddr[5:0]];
    assign dmemRdData  = dmem[dmemAddr[7:0]];
    assign rfReadDataA = (rfReadRegA == '0) ? '0 :
                         (rfWe && rfWriteReg == rfReadRegA) ? rfWriteData : rf[rfReadRegA];
    assign rfReadDataB = (rfReadRegB == '0) ? '0 :
                         (rfWe && rfWriteReg == rfReadRegB) ? rfWriteData : rf[rfReadRegB];

    always @(posedge clock) begin
        if (rfWe && rfWriteReg != '0) rf[rfWriteReg] <= rfWriteData;
        if (dmemWe) dmem[dmemAddr[7:0]] <= dmemWrData;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic checkRegWrite();
        logic [rw-1:0] idx;
        logic [dw-1:0] val;
        regWriteExpected: assert (expRegIdx.size() != 0)
            else abortRun($sformatf("Register write to r%0d after the last expected one",
                                    rfWriteReg));
        idx = expRegIdx.pop_front();
        val = expRegVal.pop_front();
        regIndexOk: assert (rfWriteReg === idx)
            else abortRun($sformatf("Error: rfWriteReg is 0x%h, expected 0x%h", rfWriteReg, idx));
        regValueOk: assert (rfWriteData === val)
            else abortRun($sformatf("Error: rfWriteData is 0x%h, expected 0x%h for r%0d",
                                    rfWriteData, val, idx));
    endtask

    task automatic checkMemWrite();
        logic [dw-1:0] addr;
        logic [dw-1:0] val;
        memWriteExpected: assert (expMemAddr.size() != 0)
            else abortRun("Store seen after the last expected store");
        addr = expMemAddr.pop_front();
        val  = expMemVal.pop_front();
        memAddrOk: assert (dmemAddr === addr)
            else abortRun($sformatf("Error: dmemAddr is 0x%h, expected 0x%h", dmemAddr, addr));
        memDataOk: assert (dmemWrData === val)
            else abortRun($sformatf("Error: dmemWrData is 0x%h, expected 0x%h",
                                    dmemWrData, val));
    endtask

    // Mid-cycle sampling, outputs settled since the rising edge
    always @(negedge clock) begin
        if (!arstN) begin
            quietInReset: assert (rfWe === 1'b0 && dmemWe === 1'b0)
                else abortRun("A write enable was high while reset was asserted");
        end else begin
            if (rfWe === 1'b1) begin
                rfNotZero: assert (rfWriteReg != '0)
                    else abortRun("Register 0 was written");
                checkRegWrite();
            end
            if (dmemWe === 1'b1) checkMemWrite();
            if (imemAddr == loopPc) loopFetches <= loopFetches + 1;
        end
    end

    // Watchdog, bounded by the model's instruction count
    initial begin
        wait (arstN === 1'b1);
        repeat (6 * refCount + 40) @(posedge clock);
        abortRun($sformatf("Timeout: final loop not reached within %0d cycles after reset",
                           6 * refCount + 40));
    end

    initial begin
        arstN       = 1'b0;
        loopFetches = 0;
        loadProgram();
        runModel();
        foreach (rf[i]) rf[i] = '0;
        foreach (dmem[i]) dmem[i] = fillWord(i[7:0]);      // Same image the model starts from
        repeat (16) @(posedge clock);
        arstN <= 1'b1;
        wait (loopFetches >= 3);                           // Loop jump executed twice by now
        @(negedge clock);
        if (expRegIdx.size() == 0 && expMemAddr.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abortRun($sformatf("Final loop reached with %0d register and %0d store writes missing",
                               expRegIdx.size(), expMemAddr.size()));
        end
    end

    // Program and model tasks, placed after the arrays they fill
`include "isaModel.svh"

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verif
design/cpuPkg.sv
design/bypassIf.sv
design/instrDecode.sv
design/alu.sv
design/hazardUnit.sv
design/executeStage.sv
design/processor.sv
verif/tbProcessor.sv
